//--- common/render_consts.svh
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// Registry slots in the model buffer
`define RENDER_MAX_MODEL_COUNT 8

// Triangle slots shared by all models
`define RENDER_MAX_TRIANGLE_COUNT 64

`define RENDER_COORD_WIDTH 12 // Signed, wraps on overflow

// Default depth of the stream FIFOs
`define RENDER_FIFO_DEPTH 4

`endif

//--- common/geom_pkg.sv
`default_nettype none

`include "render_consts.svh"

package geom_pkg;

    // Screen-space coordinate, two's complement
    typedef logic signed [`RENDER_COORD_WIDTH-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Three vertices, index 0 in the low bits
    typedef vertex_t [2:0] triangle_t;

    // Sideband carried with each triangle
    typedef struct packed {
        logic last; // Final triangle of a draw
    } triangle_metadata_t;

endpackage

`default_nettype wire

//--- common/modelbuf_pkg.sv
`default_nettype none

`include "render_consts.svh"

package modelbuf_pkg;

    typedef logic [$clog2(`RENDER_MAX_MODEL_COUNT)-1:0] model_id_t;
    typedef logic [$clog2(`RENDER_MAX_TRIANGLE_COUNT)-1:0] tri_index_t;

    // One beat on the write side
    typedef struct packed {
        model_id_t           model_id;
        geom_pkg::triangle_t triangle;
    } modelbuf_data_t;

    // Triangle lookup, index is relative to the model start
    typedef struct packed {
        model_id_t  model_index;
        tri_index_t triangle_index;
    } modelbuf_read_data_t;

    typedef struct packed {
        model_id_t         model_id;
        geom_pkg::vertex_t offset; // Added to every vertex of the model
    } draw_cmd_t;

endpackage

`default_nettype wire

//--- common/tri_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tri_stream_if;

    logic                          valid;
    logic                          ready;
    geom_pkg::triangle_t           data;
    geom_pkg::triangle_metadata_t  meta;

    modport source (
        output valid,
        output data,
        output meta,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  meta,
        output ready
    );

endinterface

`default_nettype wire

//--- model_buffer/model_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module model_buffer #(
    parameter int max_model_count    = `RENDER_MAX_MODEL_COUNT,
    parameter int max_triangle_count = `RENDER_MAX_TRIANGLE_COUNT
) (
    input  wire                                clk,
    input  wire                                rstn,

    input  wire                                write_in_valid,
    output logic                               write_in_ready,
    input  wire modelbuf_pkg::modelbuf_data_t  write_in_data,

    input  wire                                read_in_valid,
    output logic                               read_in_ready,
    input  wire modelbuf_pkg::modelbuf_read_data_t read_in_data,

    tri_stream_if.source                       read_out
);

    localparam int mid_w  = $clog2(max_model_count);
    localparam int addr_w = $clog2(max_triangle_count);
    localparam int size_w = $clog2(max_triangle_count + 1); // Must hold a full store

    typedef logic [mid_w-1:0]  mid_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [size_w-1:0] size_t;

    typedef enum logic [1:0] {
        slot_empty   = 2'b00,
        slot_writing = 2'b01,
        slot_written = 2'b10
    } slot_state_t;

    typedef struct packed {
        addr_t       start; // First triangle in the store
        size_t       size;
        slot_state_t state;
    } reg_entry_t;

    reg_entry_t          registry [max_model_count];
    geom_pkg::triangle_t store [max_triangle_count];

    addr_t addr_next;   // Next free slot in the store
    mid_t  prev_model;  // Model of the last accepted write
    logic  prev_valid;

    mid_t  wr_model;
    logic  write_en;
    logic  model_change;

    mid_t  rd_model;
    addr_t rd_index;
    addr_t rd_addr;

    // Write side
    assign wr_model     = mid_t'(write_in_data.model_id);
    assign model_change = prev_valid && (prev_model != wr_model);

    // A closed model takes no more triangles
    assign write_in_ready = (registry[wr_model].state != slot_written);
    assign write_en       = write_in_valid && write_in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_next  <= '0;
            prev_model <= '0;
            prev_valid <= 1'b0;
            for (int m = 0; m < max_model_count; m++) begin
                registry[m].start <= '0;
                registry[m].size  <= '0;
                registry[m].state <= slot_empty;
            end
        end else if (write_en) begin
            addr_next  <= addr_next + 1'b1;
            prev_model <= wr_model;
            prev_valid <= 1'b1;
            registry[wr_model].size <= registry[wr_model].size + 1'b1;

            // First triangle opens the model at the free pointer
            if (registry[wr_model].state == slot_empty) begin
                registry[wr_model].start <= addr_next;
                registry[wr_model].state <= slot_writing;
            end

            // Switching models closes the one before
            if (model_change && registry[prev_model].state == slot_writing) begin
                registry[prev_model].state <= slot_written;
            end
        end
    end

    // Triangles are appended in arrival order, so the free pointer is the write address
    always_ff @(posedge clk) begin
        if (write_en) begin
            store[addr_next] <= write_in_data.triangle;
        end
    end

    // Read side, combinational lookup
    assign rd_model = mid_t'(read_in_data.model_index);
    assign rd_index = addr_t'(read_in_data.triangle_index);
    assign rd_addr  = registry[rd_model].start + rd_index;

    assign read_in_ready  = read_out.ready; // Back-pressure straight through
    assign read_out.valid = read_in_valid;
    assign read_out.data  = store[rd_addr];

    always_comb begin
        read_out.meta.last = ((size_t'(rd_index) + 1'b1) == registry[rd_model].size);
    end

endmodule

`default_nettype wire

//--- rtl/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = `RENDER_FIFO_DEPTH
) (
    input  wire      clk,
    input  wire      rstn,

    input  wire      in_valid,
    output logic     in_ready,
    input  wire payload_t in_data,

    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w-1:0]   wr_ptr;
    logic [count_w-1:0] count;

    logic push;
    logic pop;

    // A pop in the same cycle frees a slot for a full FIFO
    assign in_ready  = (count != count_w'(depth)) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/model_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module model_fetch (
    input  wire                                clk,
    input  wire                                rstn,

    input  wire                                draw_valid,
    output logic                               draw_ready,
    input  wire modelbuf_pkg::draw_cmd_t       draw_cmd,

    output logic                               read_valid,
    input  wire                                read_ready,
    output modelbuf_pkg::modelbuf_read_data_t  read_data,
    input  wire                                last_seen,  // Last flag of the current read

    output geom_pkg::vertex_t                  offset
);

    typedef enum logic {
        fetch_idle,
        fetch_busy
    } fetch_state_t;

    fetch_state_t state;

    modelbuf_pkg::tri_index_t cur_index;
    modelbuf_pkg::model_id_t  cur_model;
    geom_pkg::vertex_t        cur_offset;

    logic draw_accept;
    logic read_accept;

    assign draw_ready  = (state == fetch_idle);
    assign draw_accept = draw_valid && draw_ready;

    assign read_valid  = (state == fetch_busy);
    assign read_accept = read_valid && read_ready;

    assign read_data.model_index    = cur_model;
    assign read_data.triangle_index = cur_index;

    // Held until the next draw is taken
    assign offset = cur_offset;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= fetch_idle;
            cur_index <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (draw_accept) begin
                        state     <= fetch_busy;
                        cur_index <= '0;
                    end
                end
                fetch_busy: begin
                    // The buffer knows the model size, so stop on its last flag
                    if (read_accept) begin
                        if (last_seen) begin
                            state <= fetch_idle;
                        end else begin
                            cur_index <= cur_index + 1'b1;
                        end
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    // Command fields
    always_ff @(posedge clk) begin
        if (draw_accept) begin
            cur_model  <= draw_cmd.model_id;
            cur_offset <= draw_cmd.offset;
        end
    end

endmodule

`default_nettype wire

//--- rtl/triangle_translate.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_translate (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire geom_pkg::vertex_t  offset,
    tri_stream_if.sink              in_tri,
    tri_stream_if.source            out_tri
);

    logic                         s1_valid;
    geom_pkg::triangle_t          s1_data;
    geom_pkg::triangle_metadata_t s1_meta;
    geom_pkg::coord_t             s1_off_y;  // Y offset of this triangle's draw

    logic                         s2_valid;
    geom_pkg::triangle_t          s2_data;
    geom_pkg::triangle_metadata_t s2_meta;

    geom_pkg::triangle_t          x_moved;
    geom_pkg::triangle_t          y_moved;

    logic s1_load;
    logic s2_load;

    assign s2_load      = !s2_valid || out_tri.ready;
    assign s1_load      = !s1_valid || s2_load;
    assign in_tri.ready = s1_load;

    assign out_tri.valid = s2_valid;
    assign out_tri.data  = s2_data;
    assign out_tri.meta  = s2_meta;

    // Sums wrap at the coordinate width
    always_comb begin
        x_moved = in_tri.data;
        y_moved = s1_data;
        for (int v = 0; v < 3; v++) begin
            x_moved[v].x = in_tri.data[v].x + offset.x;
            y_moved[v].y = s1_data[v].y + s1_off_y;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_load) s1_valid <= in_tri.valid;
            if (s2_load) s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load && in_tri.valid) begin
            s1_data  <= x_moved;
            s1_meta  <= in_tri.meta;
            s1_off_y <= offset.y; // Travels with the triangle, safe if a new draw starts
        end
        if (s2_load && s1_valid) begin
            s2_data <= y_moved;
            s2_meta <= s1_meta;
        end
    end

endmodule

`default_nettype wire

//--- rtl/render_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module render_frontend (
    input  wire                            clk,
    input  wire                            rstn,

    input  wire                            write_valid,
    output logic                           write_ready,
    input  wire modelbuf_pkg::model_id_t   write_model_id,
    input  wire geom_pkg::triangle_t       write_triangle,

    input  wire                            draw_valid,
    output logic                           draw_ready,
    input  wire modelbuf_pkg::model_id_t   draw_model_id,
    input  wire geom_pkg::vertex_t         draw_offset,

    output logic                           out_valid,
    input  wire                            out_ready,
    output geom_pkg::triangle_t            out_triangle,
    output logic                           out_last
);

    typedef struct packed {
        geom_pkg::triangle_t triangle;
        logic                last;
    } out_item_t;

    modelbuf_pkg::modelbuf_data_t      write_beat;
    modelbuf_pkg::modelbuf_data_t      wbuf_data;
    logic                              wbuf_valid;
    logic                              wbuf_ready;

    modelbuf_pkg::draw_cmd_t           draw_cmd;

    modelbuf_pkg::modelbuf_read_data_t read_data;
    logic                              read_valid;
    logic                              read_ready;

    geom_pkg::vertex_t                 offset;
    out_item_t                         xlat_item;
    out_item_t                         out_item;

    tri_stream_if fetch_if ();
    tri_stream_if xlat_if ();

    assign write_beat.model_id = write_model_id;
    assign write_beat.triangle = write_triangle;

    assign draw_cmd.model_id = draw_model_id;
    assign draw_cmd.offset   = draw_offset;

    stream_fifo #(
        .payload_t (modelbuf_pkg::modelbuf_data_t),
        .depth     (`RENDER_FIFO_DEPTH)
    ) write_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (write_valid),
        .in_ready  (write_ready),
        .in_data   (write_beat),
        .out_valid (wbuf_valid),
        .out_ready (wbuf_ready),
        .out_data  (wbuf_data)
    );

    model_buffer #(
        .max_model_count    (`RENDER_MAX_MODEL_COUNT),
        .max_triangle_count (`RENDER_MAX_TRIANGLE_COUNT)
    ) model_buffer_inst (
        .clk            (clk),
        .rstn           (rstn),
        .write_in_valid (wbuf_valid),
        .write_in_ready (wbuf_ready),
        .write_in_data  (wbuf_data),
        .read_in_valid  (read_valid),
        .read_in_ready  (read_ready),
        .read_in_data   (read_data),
        .read_out       (fetch_if)
    );

    model_fetch model_fetch_inst (
        .clk        (clk),
        .rstn       (rstn),
        .draw_valid (draw_valid),
        .draw_ready (draw_ready),
        .draw_cmd   (draw_cmd),
        .read_valid (read_valid),
        .read_ready (read_ready),
        .read_data  (read_data),
        .last_seen  (fetch_if.meta.last),
        .offset     (offset)
    );

    triangle_translate triangle_translate_inst (
        .clk     (clk),
        .rstn    (rstn),
        .offset  (offset),
        .in_tri  (fetch_if),
        .out_tri (xlat_if)
    );

    // Last flag rides next to the triangle in the output FIFO
    assign xlat_item.triangle = xlat_if.data;
    assign xlat_item.last     = xlat_if.meta.last;

    stream_fifo #(
        .payload_t (out_item_t),
        .depth     (`RENDER_FIFO_DEPTH)
    ) out_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (xlat_if.valid),
        .in_ready  (xlat_if.ready),
        .in_data   (xlat_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_item)
    );

    assign out_triangle = out_item.triangle;
    assign out_last     = out_item.last;

endmodule

`default_nettype wire

//--- test/render_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "render_consts.svh"

module render_frontend_tb;

    typedef enum logic [2:0] {
        op_write,
        op_draw,
        op_refuse,
        op_drain,
        op_stall,
        op_reset
    } op_kind_t;

    typedef struct {
        op_kind_t            kind;
        int                  model;   // Also the on/off flag of op_stall
        geom_pkg::triangle_t tri_val;
        int                  off_x;
        int                  off_y;
    } op_t;

    logic                    clk;
    logic                    rstn;
    logic                    write_valid;
    logic                    write_ready;
    modelbuf_pkg::model_id_t write_model_id;
    geom_pkg::triangle_t     write_triangle;
    logic                    draw_valid;
    logic                    draw_ready;
    modelbuf_pkg::model_id_t draw_model_id;
    geom_pkg::vertex_t       draw_offset;
    logic                    out_valid;
    logic                    out_ready;
    geom_pkg::triangle_t     out_triangle;
    logic                    out_last;

    // Reference copy of every model's triangles
    geom_pkg::triangle_t ref_store [`RENDER_MAX_MODEL_COUNT][`RENDER_MAX_TRIANGLE_COUNT];
    int                  ref_count [`RENDER_MAX_MODEL_COUNT];

    geom_pkg::triangle_t exp_tri [$];
    logic                exp_last [$];
    op_t                 table_q [$];
    logic                stall_on;
    logic                writes_blocked; // Refused beats sit in the write FIFO until reset

    render_frontend render_frontend_inst (
        .clk            (clk),
        .rstn           (rstn),
        .write_valid    (write_valid),
        .write_ready    (write_ready),
        .write_model_id (write_model_id),
        .write_triangle (write_triangle),
        .draw_valid     (draw_valid),
        .draw_ready     (draw_ready),
        .draw_model_id  (draw_model_id),
        .draw_offset    (draw_offset),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_triangle   (out_triangle),
        .out_last       (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Output back-pressure drops ready about 30% of cycles while stalling
    initial begin
        int seed_ret;
        seed_ret = $urandom(14);
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            out_ready = stall_on ? ($urandom_range(99) >= 30) : 1'b1;
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [71:0] got,
                               input logic [71:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h expected %h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic geom_pkg::triangle_t make_tri(input int tag);
        geom_pkg::triangle_t t;
        for (int v = 0; v < 3; v++) begin
            t[v].x = geom_pkg::coord_t'(tag * 97 + v * 311 - 1500);
            t[v].y = geom_pkg::coord_t'(2000 - tag * 53 - v * 177);
        end
        return t;
    endfunction

    // Expected vertex positions wrap modulo 4096
    function automatic geom_pkg::triangle_t shift_tri(input geom_pkg::triangle_t t,
                                                      input int ox, input int oy);
        geom_pkg::triangle_t r;
        int sx;
        int sy;
        for (int v = 0; v < 3; v++) begin
            sx = ((int'(t[v].x) + ox) % 4096 + 4096) % 4096;
            sy = ((int'(t[v].y) + oy) % 4096 + 4096) % 4096;
            r[v].x = geom_pkg::coord_t'(sx);
            r[v].y = geom_pkg::coord_t'(sy);
        end
        return r;
    endfunction

    function automatic void add_op(input op_kind_t kind, input int model,
                                   input int tag, input int ox, input int oy);
        op_t o;
        o.kind    = kind;
        o.model   = model;
        o.tri_val = make_tri(tag);
        o.off_x   = ox;
        o.off_y   = oy;
        table_q.push_back(o);
    endfunction

    function automatic void build_table();
        // Models 3 and 4 sit at later addresses and model 4 stays open
        for (int i = 0; i < 3; i++) add_op(op_write, 0, i, 0, 0);
        add_op(op_write, 1, 10, 0, 0);
        for (int i = 0; i < 5; i++) add_op(op_write, 2, 20 + i, 0, 0);
        add_op(op_write, 3, 30, 0, 0);
        add_op(op_write, 3, 31, 0, 0);
        add_op(op_write, 4, 40, 0, 0);
        add_op(op_drain, 0, 0, 0, 0);
        for (int m = 0; m < 3; m++) add_op(op_draw, m, 0, 0, 0);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_draw, 0, 0, 100, -50);
        add_op(op_draw, 2, 0, -2047, 2047);
        add_op(op_draw, 1, 0, -2048, -1);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_refuse, 0, 900, 0, 0);
        add_op(op_draw, 0, 0, 5, 7);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_stall, 1, 0, 0, 0);
        add_op(op_draw, 2, 0, 300, -300);
        add_op(op_draw, 0, 0, -1, 1);
        add_op(op_draw, 2, 0, 1999, 12);
        add_op(op_draw, 1, 0, 0, 0);
        add_op(op_draw, 3, 0, -777, 555);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_stall, 0, 0, 0, 0);
        add_op(op_draw, 3, 0, 64, 64);
        add_op(op_draw, 1, 0, -64, 8);
        add_op(op_draw, 2, 0, 2047, -2048);
        add_op(op_draw, 0, 0, 1, 2);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_reset, 0, 0, 0, 0);
        for (int i = 0; i < 4; i++) add_op(op_write, 0, 50 + i, 0, 0);
        add_op(op_write, 5, 60, 0, 0);
        add_op(op_drain, 0, 0, 0, 0);
        add_op(op_draw, 0, 0, -9, 33);
        add_op(op_drain, 0, 0, 0, 0);
    endfunction

    // A transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rstn && out_valid && out_ready) begin
            if (exp_tri.size() == 0) begin
                $display("A triangle came out while no draw was pending");
                abort_run();
            end
            check_value("out_triangle", 72'(out_triangle), 72'(exp_tri[0]));
            check_value("out_last", 72'(out_last), 72'(exp_last[0]));
            void'(exp_tri.pop_front());
            void'(exp_last.pop_front());
        end
    end

    task automatic reset_dut();
        rstn        = 1'b0;
        write_valid = 1'b0;
        draw_valid  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        for (int m = 0; m < `RENDER_MAX_MODEL_COUNT; m++) ref_count[m] = 0;
        exp_tri.delete();
        exp_last.delete();
        writes_blocked = 1'b0;
        @(negedge clk);
        check_value("draw_ready", 72'(draw_ready), 72'(1));
        check_value("out_valid", 72'(out_valid), 72'(0));
        @(posedge clk);
        #2;
    endtask

    task automatic load_triangle(input int model, input geom_pkg::triangle_t t);
        int waited;
        waited         = 0;
        write_valid    = 1'b1;
        write_model_id = modelbuf_pkg::model_id_t'(model);
        write_triangle = t;
        @(negedge clk);
        while (!write_ready) begin
            waited++;
            if (waited >= 200) begin
                $display("Timeout, write_ready stayed low for 200 cycles");
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        write_valid = 1'b0;
        ref_store[model][ref_count[model]] = t;
        ref_count[model]++;
    endtask

    task automatic issue_draw(input int model, input int ox, input int oy);
        int waited;
        waited        = 0;
        draw_valid    = 1'b1;
        draw_model_id = modelbuf_pkg::model_id_t'(model);
        draw_offset.x = geom_pkg::coord_t'(ox);
        draw_offset.y = geom_pkg::coord_t'(oy);
        @(negedge clk);
        while (!draw_ready) begin
            waited++;
            if (waited >= 200) begin
                $display("Timeout, draw_ready stayed low for 200 cycles");
                abort_run();
            end
            @(negedge clk);
        end
        for (int i = 0; i < ref_count[model]; i++) begin
            exp_tri.push_back(shift_tri(ref_store[model][i], ox, oy));
            exp_last.push_back(i == ref_count[model] - 1);
        end
        @(posedge clk);
        #2;
        draw_valid = 1'b0;
    endtask

    // The write FIFO takes a few beats before the refusal shows on write_ready
    task automatic expect_refusal(input int model, input geom_pkg::triangle_t t);
        int waited;
        waited         = 0;
        write_valid    = 1'b1;
        write_model_id = modelbuf_pkg::model_id_t'(model);
        write_triangle = t;
        @(negedge clk);
        while (write_ready) begin
            waited++;
            if (waited >= 20) begin
                $display("A write to a closed model was never refused");
                abort_run();
            end
            @(negedge clk);
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (write_ready) begin
                $display("A refused write to a closed model was taken later");
                abort_run();
            end
        end
        @(posedge clk);
        #2;
        write_valid    = 1'b0;
        writes_blocked = 1'b1;
    endtask

    task automatic drain_pending();
        int waited;
        waited = 0;
        while (exp_tri.size() != 0 || (!writes_blocked && render_frontend_inst.wbuf_valid)) begin
            waited++;
            if (waited >= 200) begin
                $display("Timeout, outputs or writes still pending after 200 cycles");
                abort_run();
            end
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        op_t op;
        rstn           = 1'b0;
        write_valid    = 1'b0;
        write_model_id = '0;
        write_triangle = '0;
        draw_valid     = 1'b0;
        draw_model_id  = '0;
        draw_offset    = '0;
        stall_on       = 1'b0;
        writes_blocked = 1'b0;
        build_table();
        @(posedge clk);
        #2;
        reset_dut();
        foreach (table_q[i]) begin
            op = table_q[i];
            case (op.kind)
                op_write:  load_triangle(op.model, op.tri_val);
                op_draw:   issue_draw(op.model, op.off_x, op.off_y);
                op_refuse: expect_refusal(op.model, op.tri_val);
                op_drain:  drain_pending();
                op_stall:  stall_on = (op.model != 0);
                op_reset:  reset_dut();
                default:   drain_pending();
            endcase
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- render_frontend.f
+incdir+common
common/geom_pkg.sv
common/modelbuf_pkg.sv
common/tri_stream_if.sv
model_buffer/model_buffer.sv
rtl/stream_fifo.sv
rtl/model_fetch.sv
rtl/triangle_translate.sv
rtl/render_frontend.sv
test/render_frontend_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = render_frontend_tb
FILELIST = render_frontend.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
